// File: hw/renameTypes.sv
/*
 * Shared sizes, widths and index types of the rename stage
 * Op kind and serializer phase enums
 * Packed structs passed between stage, map table and active list
 */
`default_nettype none

package renameTypes;

    // Group and register file sizes
    localparam int RENAME_WIDTH = 2;
    localparam int LOG_REG_NUM = 16;
    localparam int PHY_REG_NUM = 32;
    localparam int FREE_LIST_DEPTH = PHY_REG_NUM - LOG_REG_NUM;
    localparam int ACTIVE_LIST_DEPTH = 16;

    localparam int LOG_REG_WIDTH = $clog2(LOG_REG_NUM);
    localparam int PHY_REG_WIDTH = $clog2(PHY_REG_NUM);
    localparam int AL_PTR_WIDTH = $clog2(ACTIVE_LIST_DEPTH);
    localparam int FL_PTR_WIDTH = $clog2(FREE_LIST_DEPTH);
    localparam int PC_WIDTH = 16;

    typedef logic [LOG_REG_WIDTH-1:0] LogRegNum;
    typedef logic [PHY_REG_WIDTH-1:0] PhyRegNum;
    typedef logic [AL_PTR_WIDTH-1:0] ActiveListPtr;
    // One extra bit so a full list is representable
    typedef logic [AL_PTR_WIDTH:0] ActiveListCount;
    typedef logic [FL_PTR_WIDTH-1:0] FreeListPtr;
    typedef logic [FL_PTR_WIDTH:0] FreeListCount;
    typedef logic [PC_WIDTH-1:0] ProgramCounter;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_SERIAL
    } OpKind;

    typedef enum logic {
        PHASE_NORMAL,
        // Serial op dispatched, waiting for its own commit
        PHASE_WAIT_OWN
    } SerialPhase;

    typedef struct packed {
        logic valid;
        OpKind kind;
        LogRegNum srcA;
        LogRegNum srcB;
        LogRegNum dst;
        logic writeReg;
        ProgramCounter pc;
    } DecodedOp;

    typedef struct packed {
        logic valid;
        OpKind kind;
        PhyRegNum phySrcA;
        PhyRegNum phySrcB;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
        logic writeReg;
        ActiveListPtr alPtr;
        ProgramCounter pc;
    } RenamedOp;

    typedef struct packed {
        LogRegNum logDst;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
        logic writeReg;
        OpKind kind;
    } ActiveListEntry;

    typedef struct packed {
        logic valid;
        ActiveListEntry entry;
    } CommitInfo;

    typedef struct packed {
        logic valid;
        PhyRegNum phyReg;
    } FreedReg;

    // writeReg here is already qualified by the slot's valid bit
    typedef struct packed {
        logic update;
        LogRegNum srcA;
        LogRegNum srcB;
        LogRegNum dst;
        logic writeReg;
    } MapRequest;

    typedef struct packed {
        PhyRegNum phySrcA;
        PhyRegNum phySrcB;
        PhyRegNum phyDst;
        PhyRegNum phyPrevDst;
    } MapResult;

endpackage

`default_nettype wire

// File: hw/renameMapTable.sv
/*
 * Logical to physical register map with identity reset
 * Free-list FIFO of physical registers
 * Bypass of older destinations to younger slots in a group
 */
`timescale 1ns/1ps
`default_nettype none

module renameMapTable (
    input  logic clk,
    input  logic rst,
    input  renameTypes::MapRequest [renameTypes::RENAME_WIDTH-1:0] mapReq,
    input  renameTypes::FreedReg freedReg,
    output renameTypes::MapResult [renameTypes::RENAME_WIDTH-1:0] mapRes,
    output logic mapAllocatable
);

    renameTypes::PhyRegNum mapTable [renameTypes::LOG_REG_NUM];
    renameTypes::PhyRegNum freeList [renameTypes::FREE_LIST_DEPTH];
    renameTypes::FreeListPtr flHead;
    renameTypes::FreeListPtr flTail;
    renameTypes::FreeListCount flCount;

    renameTypes::FreeListCount needed;
    renameTypes::FreeListCount popCount;
    renameTypes::PhyRegNum allocDst [renameTypes::RENAME_WIDTH];

    // Each writing slot takes the next free entry in slot order
    always_comb begin
        needed = '0;
        popCount = '0;
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            allocDst[i] = freeList[flHead + needed[renameTypes::FL_PTR_WIDTH-1:0]];
            if (mapReq[i].writeReg) begin
                needed = needed + 1'b1;
                if (mapReq[i].update) begin
                    popCount = popCount + 1'b1;
                end
            end
        end
        mapAllocatable = flCount >= needed;
    end

    always_comb begin
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            mapRes[i].phySrcA = mapTable[mapReq[i].srcA];
            mapRes[i].phySrcB = mapTable[mapReq[i].srcB];
            mapRes[i].phyPrevDst = mapTable[mapReq[i].dst];
            mapRes[i].phyDst = allocDst[i];

            // Youngest older writer of the same register wins
            for (int j = 0; j < i; j++) begin
                if (mapReq[j].writeReg) begin
                    if (mapReq[j].dst == mapReq[i].srcA) begin
                        mapRes[i].phySrcA = allocDst[j];
                    end
                    if (mapReq[j].dst == mapReq[i].srcB) begin
                        mapRes[i].phySrcB = allocDst[j];
                    end
                    if (mapReq[j].dst == mapReq[i].dst) begin
                        mapRes[i].phyPrevDst = allocDst[j];
                    end
                end
            end

            // Non-writing ops carry no destination
            if (!mapReq[i].writeReg) begin
                mapRes[i].phyDst = '0;
                mapRes[i].phyPrevDst = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < renameTypes::LOG_REG_NUM; i++) begin
                mapTable[i] <= renameTypes::PhyRegNum'(i);
            end
            for (int i = 0; i < renameTypes::FREE_LIST_DEPTH; i++) begin
                freeList[i] <= renameTypes::PhyRegNum'(renameTypes::LOG_REG_NUM + i);
            end
            flHead <= '0;
            flTail <= '0;
            flCount <= renameTypes::FreeListCount'(renameTypes::FREE_LIST_DEPTH);
        end else begin
            // Later slots overwrite earlier ones on the same register
            for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
                if (mapReq[i].update && mapReq[i].writeReg) begin
                    mapTable[mapReq[i].dst] <= allocDst[i];
                end
            end
            if (freedReg.valid) begin
                freeList[flTail] <= freedReg.phyReg;
                flTail <= flTail + 1'b1;
            end
            flHead <= flHead + popCount[renameTypes::FL_PTR_WIDTH-1:0];
            flCount <= flCount - popCount + renameTypes::FreeListCount'(freedReg.valid);
        end
    end

endmodule

`default_nettype wire

// File: hw/activeList.sv
/*
 * Circular in-order active list
 * Pushes up to RENAME_WIDTH entries per cycle, pops one on commit
 */
`timescale 1ns/1ps
`default_nettype none

module activeList (
    input  logic clk,
    input  logic rst,
    input  logic [renameTypes::RENAME_WIDTH-1:0] pushValid,
    input  renameTypes::ActiveListEntry [renameTypes::RENAME_WIDTH-1:0] pushEntry,
    input  logic commitReq,
    output renameTypes::ActiveListPtr [renameTypes::RENAME_WIDTH-1:0] tailPtr,
    output logic allocatable,
    output logic empty,
    output renameTypes::CommitInfo commitOut,
    output renameTypes::FreedReg freedReg
);

    renameTypes::ActiveListEntry entries [renameTypes::ACTIVE_LIST_DEPTH];
    renameTypes::ActiveListPtr head;
    renameTypes::ActiveListPtr tail;
    renameTypes::ActiveListCount count;
    renameTypes::ActiveListCount pushCount;
    logic pop;

    // Slots are packed in order behind the current tail
    always_comb begin
        pushCount = '0;
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            tailPtr[i] = tail + pushCount[renameTypes::AL_PTR_WIDTH-1:0];
            if (pushValid[i]) begin
                pushCount = pushCount + 1'b1;
            end
        end
    end

    assign empty = count == '0;
    assign allocatable = (renameTypes::ACTIVE_LIST_DEPTH - count) >= renameTypes::RENAME_WIDTH;
    assign pop = commitReq && !empty;

    // Commit straight from the head entry
    always_comb begin
        commitOut.valid = pop;
        commitOut.entry = entries[head];
        freedReg.valid = pop && entries[head].writeReg;
        freedReg.phyReg = entries[head].phyPrevDst;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            if (pushValid[i]) begin
                entries[tailPtr[i]] <= pushEntry[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            tail <= tail + pushCount[renameTypes::AL_PTR_WIDTH-1:0];
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + pushCount - renameTypes::ActiveListCount'(pop);
        end
    end

endmodule

`default_nettype wire

// File: hw/renameStage.sv
/*
 * Rename pipeline register and stall decision
 * Serializer FSM for ops that must run alone
 * Assembly of map and active-list results into dispatch packets
 */
`timescale 1ns/1ps
`default_nettype none

module renameStage (
    input  logic clk,
    input  logic rst,
    input  renameTypes::DecodedOp [renameTypes::RENAME_WIDTH-1:0] decodeOps,
    input  logic dispatchStall,
    input  renameTypes::MapResult [renameTypes::RENAME_WIDTH-1:0] mapRes,
    input  logic mapAllocatable,
    input  renameTypes::ActiveListPtr [renameTypes::RENAME_WIDTH-1:0] alTailPtr,
    input  logic alAllocatable,
    input  logic alEmpty,
    output logic stallUpper,
    output renameTypes::MapRequest [renameTypes::RENAME_WIDTH-1:0] mapReq,
    output logic [renameTypes::RENAME_WIDTH-1:0] alPushValid,
    output renameTypes::ActiveListEntry [renameTypes::RENAME_WIDTH-1:0] alPushEntry,
    output renameTypes::RenamedOp [renameTypes::RENAME_WIDTH-1:0] dispatchOps
);

    renameTypes::DecodedOp [renameTypes::RENAME_WIDTH-1:0] pipeReg;
    logic [renameTypes::RENAME_WIDTH-1:0] valid;
    logic [renameTypes::RENAME_WIDTH-1:0] update;
    logic serialize;
    renameTypes::SerialPhase phase;
    renameTypes::SerialPhase nextPhase;

    // Held op stays in place while the stage stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stallUpper) begin
            pipeReg <= decodeOps;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= renameTypes::PHASE_NORMAL;
        end else if (!dispatchStall) begin
            phase <= nextPhase;
        end
    end

    // Serial ops only ever arrive alone in slot 0
    always_comb begin
        serialize = 1'b0;
        nextPhase = renameTypes::PHASE_NORMAL;
        if (phase == renameTypes::PHASE_NORMAL) begin
            if (valid[0] && pipeReg[0].kind == renameTypes::OP_SERIAL) begin
                if (!alEmpty) begin
                    // Drain all older ops first
                    serialize = 1'b1;
                end else begin
                    nextPhase = renameTypes::PHASE_WAIT_OWN;
                end
            end
        end else if (!alEmpty) begin
            serialize = 1'b1;
            nextPhase = renameTypes::PHASE_WAIT_OWN;
        end
    end

    always_comb begin
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            valid[i] = pipeReg[i].valid;
        end
        stallUpper = ((|valid) && (!mapAllocatable || !alAllocatable))
            || serialize || dispatchStall;
    end

    always_comb begin
        for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
            update[i] = valid[i] && !stallUpper;

            mapReq[i].update = update[i];
            mapReq[i].srcA = pipeReg[i].srcA;
            mapReq[i].srcB = pipeReg[i].srcB;
            mapReq[i].dst = pipeReg[i].dst;
            // Kept free of the stall so allocatable has no loop through it
            mapReq[i].writeReg = valid[i] && pipeReg[i].writeReg;

            alPushValid[i] = update[i];
            alPushEntry[i].logDst = pipeReg[i].dst;
            alPushEntry[i].phyDst = mapRes[i].phyDst;
            alPushEntry[i].phyPrevDst = mapRes[i].phyPrevDst;
            alPushEntry[i].writeReg = pipeReg[i].writeReg;
            alPushEntry[i].kind = pipeReg[i].kind;

            dispatchOps[i].valid = update[i];
            dispatchOps[i].kind = pipeReg[i].kind;
            dispatchOps[i].phySrcA = mapRes[i].phySrcA;
            dispatchOps[i].phySrcB = mapRes[i].phySrcB;
            dispatchOps[i].phyDst = mapRes[i].phyDst;
            dispatchOps[i].phyPrevDst = mapRes[i].phyPrevDst;
            dispatchOps[i].writeReg = pipeReg[i].writeReg;
            dispatchOps[i].alPtr = alTailPtr[i];
            dispatchOps[i].pc = pipeReg[i].pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/renameCore.sv
/*
 * Top level of the rename block
 * Connects the stage, the map table and the active list
 */
`timescale 1ns/1ps
`default_nettype none

module renameCore (
    input  logic clk,
    input  logic rst,
    input  renameTypes::DecodedOp [renameTypes::RENAME_WIDTH-1:0] decodeOps,
    input  logic dispatchStall,
    input  logic commitReq,
    output logic stallUpper,
    output renameTypes::RenamedOp [renameTypes::RENAME_WIDTH-1:0] dispatchOps,
    output renameTypes::CommitInfo commitOut
);

    renameTypes::MapRequest [renameTypes::RENAME_WIDTH-1:0] mapReq;
    renameTypes::MapResult [renameTypes::RENAME_WIDTH-1:0] mapRes;
    logic mapAllocatable;
    logic [renameTypes::RENAME_WIDTH-1:0] alPushValid;
    renameTypes::ActiveListEntry [renameTypes::RENAME_WIDTH-1:0] alPushEntry;
    renameTypes::ActiveListPtr [renameTypes::RENAME_WIDTH-1:0] alTailPtr;
    logic alAllocatable;
    logic alEmpty;
    renameTypes::FreedReg freedReg;

    renameStage renameStage_inst (
        .clk            (clk),
        .rst            (rst),
        .decodeOps      (decodeOps),
        .dispatchStall  (dispatchStall),
        .mapRes         (mapRes),
        .mapAllocatable (mapAllocatable),
        .alTailPtr      (alTailPtr),
        .alAllocatable  (alAllocatable),
        .alEmpty        (alEmpty),
        .stallUpper     (stallUpper),
        .mapReq         (mapReq),
        .alPushValid    (alPushValid),
        .alPushEntry    (alPushEntry),
        .dispatchOps    (dispatchOps)
    );

    renameMapTable renameMapTable_inst (
        .clk            (clk),
        .rst            (rst),
        .mapReq         (mapReq),
        .freedReg       (freedReg),
        .mapRes         (mapRes),
        .mapAllocatable (mapAllocatable)
    );

    activeList activeList_inst (
        .clk         (clk),
        .rst         (rst),
        .pushValid   (alPushValid),
        .pushEntry   (alPushEntry),
        .commitReq   (commitReq),
        .tailPtr     (alTailPtr),
        .allocatable (alAllocatable),
        .empty       (alEmpty),
        .commitOut   (commitOut),
        .freedReg    (freedReg)
    );

endmodule

`default_nettype wire

// File: sim/renameCoreTasks.svh
/*
 * Drive, wait and compare tasks for the rename testbench
 * Reference model steps for rename and commit
 * Xorshift random number source
 */
`ifndef RENAME_CORE_TASKS_SVH
`define RENAME_CORE_TASKS_SVH

task automatic failRun(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
endtask

task automatic compareRenamed(input string name, input renameTypes::RenamedOp act,
                              input renameTypes::RenamedOp exp);
    if (act !== exp) begin
        failRun($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, name, act, exp));
    end
endtask

task automatic compareCommit(input string name, input renameTypes::CommitInfo act,
                             input renameTypes::CommitInfo exp);
    if (act !== exp) begin
        failRun($sformatf("** Error at %0t ns: %s is %h, expected %h", $time, name, act, exp));
    end
endtask

function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

function automatic renameTypes::DecodedOp makeOp(input renameTypes::OpKind kind,
                                                 input int srcA, input int srcB,
                                                 input int dst, input logic writeReg,
                                                 input int pc);
    renameTypes::DecodedOp op;
    op.valid = 1'b1;
    op.kind = kind;
    op.srcA = renameTypes::LogRegNum'(srcA);
    op.srcB = renameTypes::LogRegNum'(srcB);
    op.dst = renameTypes::LogRegNum'(dst);
    op.writeReg = writeReg;
    op.pc = renameTypes::ProgramCounter'(pc);
    return op;
endfunction

// Reset the DUT for two cycles and bring the model back to its reset state
task automatic resetDut();
    @(negedge clk);
    rst = 1'b1;
    decodeOps = '0;
    dispatchStall = 1'b0;
    commitReq = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < renameTypes::LOG_REG_NUM; i++) begin
        refMap[i] = renameTypes::PhyRegNum'(i);
    end
    refFree.delete();
    for (int i = renameTypes::LOG_REG_NUM; i < renameTypes::PHY_REG_NUM; i++) begin
        refFree.push_back(renameTypes::PhyRegNum'(i));
    end
    refAl.delete();
    refTail = '0;
    heldGroup = '0;
endtask

// Holds the group on decodeOps until the stage captures it
task automatic presentGroup(input renameTypes::DecodedOp op0, input renameTypes::DecodedOp op1);
    int waited;
    waited = 0;
    @(negedge clk);
    decodeOps[0] = op0;
    decodeOps[1] = op1;
    #1;
    while (stallUpper) begin
        waited++;
        if (waited > MAX_WAIT) begin
            failRun("Decode group was never accepted, stallUpper stayed high");
        end
        @(negedge clk);
        #1;
    end
    heldGroup[0] = op0;
    heldGroup[1] = op1;
    @(negedge clk);
    decodeOps = '0;
endtask

task automatic waitDispatch();
    int waited;
    waited = 0;
    #1;
    while (stallUpper) begin
        waited++;
        if (waited > MAX_WAIT) begin
            failRun("Held group never dispatched, stallUpper stayed high");
        end
        @(negedge clk);
        #1;
    end
endtask

// Rename one op in program order against the model
task automatic renameInModel(input renameTypes::DecodedOp op,
                             output renameTypes::RenamedOp expOp);
    renameTypes::ActiveListEntry entry;
    expOp = '0;
    expOp.valid = 1'b1;
    expOp.kind = op.kind;
    expOp.writeReg = op.writeReg;
    expOp.pc = op.pc;
    expOp.phySrcA = refMap[op.srcA];
    expOp.phySrcB = refMap[op.srcB];
    if (op.writeReg) begin
        expOp.phyDst = refFree.pop_front();
        expOp.phyPrevDst = refMap[op.dst];
        refMap[op.dst] = expOp.phyDst;
    end
    expOp.alPtr = refTail;
    refTail = refTail + 1'b1;
    entry.logDst = op.dst;
    entry.phyDst = expOp.phyDst;
    entry.phyPrevDst = expOp.phyPrevDst;
    entry.writeReg = op.writeReg;
    entry.kind = op.kind;
    refAl.push_back(entry);
endtask

task automatic expectDispatch();
    renameTypes::RenamedOp expOp;
    waitDispatch();
    for (int i = 0; i < renameTypes::RENAME_WIDTH; i++) begin
        if (!heldGroup[i].valid) begin
            if (dispatchOps[i].valid) begin
                failRun($sformatf("Empty slot %0d dispatched a valid op", i));
            end
        end else begin
            renameInModel(heldGroup[i], expOp);
            compareRenamed($sformatf("dispatchOps[%0d]", i), dispatchOps[i], expOp);
        end
    end
    heldGroup = '0;
endtask

task automatic commitOne();
    renameTypes::CommitInfo expInfo;
    if (refAl.size() == 0) begin
        failRun("Commit requested while the model active list is empty");
    end
    expInfo.valid = 1'b1;
    expInfo.entry = refAl.pop_front();
    @(negedge clk);
    commitReq = 1'b1;
    #1;
    compareCommit("commitOut", commitOut, expInfo);
    // Freed register is back in the pool from the next cycle
    if (expInfo.entry.writeReg) begin
        refFree.push_back(expInfo.entry.phyPrevDst);
    end
    @(negedge clk);
    commitReq = 1'b0;
endtask

task automatic drainActiveList();
    while (refAl.size() > 0) begin
        commitOne();
    end
endtask

task automatic checkHeld(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        #1;
        if (!stallUpper) begin
            failRun("stallUpper dropped while the stage should hold its group");
        end
        if (dispatchOps[0].valid || dispatchOps[1].valid) begin
            failRun("An op was dispatched while the stage was stalled");
        end
        if (commitOut.valid !== 1'b0) begin
            failRun("commitOut.valid was set although no commit was requested");
        end
    end
endtask

`endif

// File: sim/renameCoreTb.sv
/*
 * Testbench for the rename block
 * Clock, reset, DUT instance, reference model state and watchdog
 * Directed tests and a seeded random stream
 */
`timescale 1ns/1ps
`default_nettype none

module renameCoreTb;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MAX_WAIT = 100;
    localparam int RANDOM_GROUPS = 30;
    localparam logic [31:0] SEED = 32'd20460;

    logic clk;
    logic rst;
    renameTypes::DecodedOp [renameTypes::RENAME_WIDTH-1:0] decodeOps;
    logic dispatchStall;
    logic commitReq;
    logic stallUpper;
    renameTypes::RenamedOp [renameTypes::RENAME_WIDTH-1:0] dispatchOps;
    renameTypes::CommitInfo commitOut;

    // Reference model of map, free FIFO and active list
    renameTypes::PhyRegNum refMap [renameTypes::LOG_REG_NUM];
    renameTypes::PhyRegNum refFree [$];
    renameTypes::ActiveListEntry refAl [$];
    renameTypes::ActiveListPtr refTail;
    // Group captured by the stage and not yet dispatched
    renameTypes::DecodedOp [renameTypes::RENAME_WIDTH-1:0] heldGroup;
    logic [31:0] rngState;

    renameCore renameCore_inst (
        .clk           (clk),
        .rst           (rst),
        .decodeOps     (decodeOps),
        .dispatchStall (dispatchStall),
        .commitReq     (commitReq),
        .stallUpper    (stallUpper),
        .dispatchOps   (dispatchOps),
        .commitOut     (commitOut)
    );

    `include "renameCoreTasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        failRun("Watchdog expired before all tests finished");
    end

    function automatic renameTypes::DecodedOp randomOp(input int pc);
        logic [31:0] r;
        r = nextRandom();
        return makeOp(renameTypes::OpKind'(r[1:0]), r[5:2], r[9:6], r[13:10], r[14], pc);
    endfunction

    task automatic checkResetMapping();
        renameTypes::RenamedOp expOp;
        resetDut();
        presentGroup(makeOp(renameTypes::OP_ALU, 3, 5, 7, 1'b1, 'h100), '0);
        waitDispatch();
        expOp = '0;
        expOp.valid = 1'b1;
        expOp.kind = renameTypes::OP_ALU;
        expOp.phySrcA = 5'd3;
        expOp.phySrcB = 5'd5;
        expOp.phyDst = 5'd16;
        expOp.phyPrevDst = 5'd7;
        expOp.writeReg = 1'b1;
        expOp.alPtr = 4'd0;
        expOp.pc = 16'h0100;
        compareRenamed("dispatchOps[0]", dispatchOps[0], expOp);
    endtask

    task automatic checkGroupBypass();
        resetDut();
        // Slot 1 reads and rewrites the register that slot 0 writes
        presentGroup(makeOp(renameTypes::OP_ALU, 1, 2, 4, 1'b1, 'h200),
                     makeOp(renameTypes::OP_LOAD, 4, 4, 4, 1'b1, 'h204));
        expectDispatch();
        drainActiveList();
    endtask

    // Fill the active list, then one more group must stall until two commits
    task automatic overflowActiveList(input logic writeReg);
        renameTypes::OpKind kind;
        kind = writeReg ? renameTypes::OP_ALU : renameTypes::OP_STORE;
        resetDut();
        for (int g = 0; g < renameTypes::ACTIVE_LIST_DEPTH / 2; g++) begin
            presentGroup(makeOp(kind, g, g + 1, 2 * g, writeReg, 'h300 + 8 * g),
                         makeOp(kind, g + 2, g + 3, 2 * g + 1, writeReg, 'h304 + 8 * g));
            expectDispatch();
        end
        presentGroup(makeOp(kind, 1, 2, 3, writeReg, 'h380),
                     makeOp(kind, 4, 5, 6, writeReg, 'h384));
        checkHeld(3);
        commitOne();
        commitOne();
        expectDispatch();
        drainActiveList();
    endtask

    task automatic exhaustResources();
        overflowActiveList(1'b0);
        overflowActiveList(1'b1);
    endtask

    task automatic reuseFreedRegs();
        int commits;
        resetDut();
        for (int g = 0; g < RANDOM_GROUPS; g++) begin
            commits = int'(nextRandom() % 3);
            while (commits > 0 && refAl.size() > 0) begin
                commitOne();
                commits--;
            end
            while (refAl.size() > renameTypes::ACTIVE_LIST_DEPTH - renameTypes::RENAME_WIDTH) begin
                commitOne();
            end
            presentGroup(randomOp('h400 + 8 * g), randomOp('h404 + 8 * g));
            expectDispatch();
        end
        drainActiveList();
    endtask

    task automatic serializeOp();
        resetDut();
        for (int g = 0; g < 2; g++) begin
            presentGroup(makeOp(renameTypes::OP_ALU, g, g + 1, g + 8, 1'b1, 'h500 + 8 * g),
                         makeOp(renameTypes::OP_ALU, g + 2, g + 3, g + 10, 1'b1, 'h504 + 8 * g));
            expectDispatch();
        end
        presentGroup(makeOp(renameTypes::OP_SERIAL, 1, 2, 3, 1'b1, 'h520), '0);
        checkHeld(4);
        repeat (3) commitOne();
        checkHeld(2);
        commitOne();
        expectDispatch();
        // Younger group waits for the serial op's own commit
        fork
            presentGroup(makeOp(renameTypes::OP_ALU, 3, 3, 5, 1'b1, 'h524),
                         makeOp(renameTypes::OP_BRANCH, 5, 3, 0, 1'b0, 'h528));
            begin
                checkHeld(4);
                commitOne();
            end
        join
        expectDispatch();
        drainActiveList();
    endtask

    task automatic holdUnderBackPressure();
        resetDut();
        presentGroup(makeOp(renameTypes::OP_ALU, 1, 2, 2, 1'b1, 'h600),
                     makeOp(renameTypes::OP_LOAD, 2, 0, 3, 1'b1, 'h604));
        dispatchStall = 1'b1;
        checkHeld(4);
        @(negedge clk);
        dispatchStall = 1'b0;
        expectDispatch();
        presentGroup(makeOp(renameTypes::OP_ALU, 3, 2, 9, 1'b1, 'h608),
                     makeOp(renameTypes::OP_ALU, 9, 9, 10, 1'b1, 'h60c));
        expectDispatch();
        drainActiveList();
    endtask

    initial begin
        rst = 1'b1;
        decodeOps = '0;
        dispatchStall = 1'b0;
        commitReq = 1'b0;
        rngState = SEED;
        checkResetMapping();
        checkGroupBypass();
        exhaustResources();
        reuseFreedRegs();
        serializeOp();
        holdUnderBackPressure();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+sim
hw/renameTypes.sv
hw/renameMapTable.sv
hw/activeList.sv
hw/renameStage.sv
hw/renameCore.sv
sim/renameCoreTb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - files:
      - hw/renameTypes.sv
      - hw/renameMapTable.sv
      - hw/activeList.sv
      - hw/renameStage.sv
      - hw/renameCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/renameCoreTb.sv
